/* pitaya_pkg.sv */
// shared widths, sample type, register map and core id
// plus the neg-slope code conversion used at the ADC and DAC pins

package pitaya_pkg;

  //----------------------------------------
  // datapath
  //----------------------------------------
  localparam int SAMPLE_W  = 14;  // converter resolution
  localparam int ADC_PIN_W = 16;  // pin bus, bits 1:0 not connected
  localparam int N_CH      = 2;   // channel a and b

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement sample

  //----------------------------------------
  // register bus
  //----------------------------------------
  localparam int ADDR_W     = 8;   // byte address
  localparam int DATA_W     = 32;
  localparam int REGION_LSB = 4;   // region field is adr[7:4]
  localparam int N_REGION   = 3;   // hk, ch a, ch b
  localparam int OFFSET_W   = 2;   // word offset, adr[3:2]

  localparam logic [DATA_W-1:0] CORE_ID = 32'h0A5C_0100;  // read only id word

  // channel register offsets
  localparam logic [OFFSET_W-1:0] REG_SETPOINT = 2'd0;
  localparam logic [OFFSET_W-1:0] REG_KP       = 2'd1;
  localparam logic [OFFSET_W-1:0] REG_LEVEL    = 2'd2;

  // housekeeping offsets
  localparam logic [OFFSET_W-1:0] HK_ID  = 2'd0;
  localparam logic [OFFSET_W-1:0] HK_LED = 2'd1;

  // negative slope offset code <-> two's complement
  // msb kept, rest inverted; the mapping is its own inverse
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

/* reg_bus_if.sv */
// register access from the bus hub into one address region
// hub drives strobe, offset and data; the region answers with read data

interface reg_bus_if;

  logic                                wr;      // one cycle write strobe
  logic [pitaya_pkg::OFFSET_W-1:0]     offset;  // word within region
  logic [pitaya_pkg::DATA_W-1:0]       wdata;   // write data
  logic [pitaya_pkg::DATA_W-1:0]       rdata;   // comb. from offset

  // bus hub side
  modport hub
  (
    output wr,
    output offset,
    output wdata,
    input  rdata
  );

  // register block side
  modport regs
  (
    input  wr,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

/* adc_frontend.sv */
// ADC input register for both channels
// drops the two unused pin bits, converts to two's complement

module adc_frontend
(
  input  logic                                adc_clk,
  input  logic                                reset_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]    adc_dat_a_i,  // ch a pins
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]    adc_dat_b_i,  // ch b pins
  output pitaya_pkg::sample_t                 sample_o [pitaya_pkg::N_CH]
);

  // raw 14 bit codes, taken from the top of the pin bus
  logic [pitaya_pkg::SAMPLE_W-1:0] pin_code [pitaya_pkg::N_CH];

  assign pin_code[0] = adc_dat_a_i[pitaya_pkg::ADC_PIN_W-1 -: pitaya_pkg::SAMPLE_W];
  assign pin_code[1] = adc_dat_b_i[pitaya_pkg::ADC_PIN_W-1 -: pitaya_pkg::SAMPLE_W];

  //----------------------------------------
  // input register
  //----------------------------------------
  // conversion ahead of the flop so reset gives a true zero sample
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < pitaya_pkg::N_CH; i++)
      begin
        sample_o[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < pitaya_pkg::N_CH; i++)
      begin
        sample_o[i] <= pitaya_pkg::neg_slope(pin_code[i]);  // offset -> 2's compl.
      end
    end
  end

endmodule

/* bus_hub.sv */
// Wishbone classic slave: region decode, ack, read mux
// housekeeping region (id word, LED register) lives here

module bus_hub
(
  input  logic                              adc_clk,
  input  logic                              reset_i,
  // Wishbone classic slave
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [pitaya_pkg::ADDR_W-1:0]     wb_adr_i,
  input  logic [pitaya_pkg::DATA_W-1:0]     wb_dat_i,
  output logic [pitaya_pkg::DATA_W-1:0]     wb_dat_o,
  output logic                              wb_ack_o,
  // housekeeping
  output logic [7:0]                        led_o,
  // channel regions
  reg_bus_if.hub                            ch_bus [1:pitaya_pkg::N_REGION-1]
);

  localparam int REGION_W = pitaya_pkg::ADDR_W - pitaya_pkg::REGION_LSB;

  logic                                req;        // new access this cycle
  logic                                wr_req;     // write part of req
  logic [REGION_W-1:0]                 region;     // adr[7:4]
  logic [pitaya_pkg::OFFSET_W-1:0]     offset;     // adr[3:2]
  logic [pitaya_pkg::DATA_W-1:0]       hk_rdata;   // region 0 read value
  logic [pitaya_pkg::DATA_W-1:0]       rd_mux;     // selected read value
  logic [pitaya_pkg::DATA_W-1:0]       region_rdata [pitaya_pkg::N_REGION];

  //----------------------------------------
  // decode
  //----------------------------------------
  // ack low gap makes a held strobe ack every second cycle
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_req = req & wb_we_i;
  assign region = wb_adr_i[pitaya_pkg::ADDR_W-1:pitaya_pkg::REGION_LSB];
  assign offset = wb_adr_i[2 +: pitaya_pkg::OFFSET_W];  // word aligned

  // fan out to channel regions, strobe only the addressed one
  for (genvar g = 1; g < pitaya_pkg::N_REGION; g++)
  begin : g_region
    assign ch_bus[g].wr     = wr_req & (region == REGION_W'(g));
    assign ch_bus[g].offset = offset;
    assign ch_bus[g].wdata  = wb_dat_i;
    assign region_rdata[g]  = ch_bus[g].rdata;
  end

  //----------------------------------------
  // housekeeping region
  //----------------------------------------
  always_comb
  begin
    case (offset)
      pitaya_pkg::HK_ID:  hk_rdata = pitaya_pkg::CORE_ID;
      pitaya_pkg::HK_LED: hk_rdata = {{(pitaya_pkg::DATA_W-8){1'b0}}, led_o};  // zero ext.
      default:            hk_rdata = '0;
    endcase
  end

  assign region_rdata[0] = hk_rdata;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_o <= '0;
    end
    else if (wr_req && region == '0 && offset == pitaya_pkg::HK_LED)
    begin
      led_o <= wb_dat_i[7:0];
    end
  end

  //----------------------------------------
  // read mux and ack
  //----------------------------------------
  // regions past N_REGION fall through to zero
  always_comb
  begin
    rd_mux = '0;
    for (int r = 0; r < pitaya_pkg::N_REGION; r++)
    begin
      if (region == REGION_W'(r))
      begin
        rd_mux = region_rdata[r];
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      wb_ack_o <= 1'b0;
    end
    else
    begin
      wb_ack_o <= req;  // single cycle, any region acks
    end
  end

  // read data, captured on the ack edge
  always_ff @(posedge adc_clk)
  begin
    if (req && !wb_we_i)
    begin
      wb_dat_o <= rd_mux;
    end
  end

endmodule

/* feedback_channel.sv */
// one feedback channel: setpoint, kp and level registers
// two stage proportional correction plus DC level, saturated to 14 bits

module feedback_channel
#(
  parameter int KP_SHIFT = 8  // product scaling, arithmetic right shift
)
(
  input  logic                  adc_clk,
  input  logic                  reset_i,
  reg_bus_if.regs               bus,       // register region
  input  pitaya_pkg::sample_t   sample_i,  // from ADC front end
  output pitaya_pkg::sample_t   result_o   // to DAC formatter
);

  localparam int KP_W   = 16;
  localparam int DIFF_W = pitaya_pkg::SAMPLE_W + 1;  // setpoint - sample
  localparam int PROD_W = KP_W + DIFF_W;
  localparam int EXT_W  = pitaya_pkg::DATA_W - pitaya_pkg::SAMPLE_W;

  localparam logic signed [PROD_W-1:0] SAT_MAX = 2**(pitaya_pkg::SAMPLE_W-1) - 1;
  localparam logic signed [PROD_W-1:0] SAT_MIN = -(2**(pitaya_pkg::SAMPLE_W-1));

  pitaya_pkg::sample_t          setpoint;
  logic signed [KP_W-1:0]       kp;
  pitaya_pkg::sample_t          level;

  logic signed [DIFF_W-1:0]     diff;      // error term
  logic signed [PROD_W-1:0]     prod_q;    // stage 1
  logic signed [PROD_W-1:0]     shifted;   // scaled product
  pitaya_pkg::sample_t          p_sat;     // proportional term, 14 bit
  logic signed [DIFF_W-1:0]     sum;       // p term + level, one guard bit

  // clamp to the signed 14 bit range
  function automatic pitaya_pkg::sample_t saturate(input logic signed [PROD_W-1:0] x);
    if (x > SAT_MAX)
      return SAT_MAX[pitaya_pkg::SAMPLE_W-1:0];
    else if (x < SAT_MIN)
      return SAT_MIN[pitaya_pkg::SAMPLE_W-1:0];
    else
      return x[pitaya_pkg::SAMPLE_W-1:0];
  endfunction

  //----------------------------------------
  // registers
  //----------------------------------------
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      setpoint <= '0;
      kp       <= '0;
      level    <= '0;
    end
    else if (bus.wr)
    begin
      case (bus.offset)
        pitaya_pkg::REG_SETPOINT: setpoint <= bus.wdata[pitaya_pkg::SAMPLE_W-1:0];
        pitaya_pkg::REG_KP:       kp       <= bus.wdata[KP_W-1:0];
        pitaya_pkg::REG_LEVEL:    level    <= bus.wdata[pitaya_pkg::SAMPLE_W-1:0];
        default:                  ;  // offset 3 unused
      endcase
    end
  end

  // readback, sign extended
  always_comb
  begin
    case (bus.offset)
      pitaya_pkg::REG_SETPOINT: bus.rdata = {{EXT_W{setpoint[pitaya_pkg::SAMPLE_W-1]}}, setpoint};
      pitaya_pkg::REG_KP:       bus.rdata = {{(pitaya_pkg::DATA_W-KP_W){kp[KP_W-1]}}, kp};
      pitaya_pkg::REG_LEVEL:    bus.rdata = {{EXT_W{level[pitaya_pkg::SAMPLE_W-1]}}, level};
      default:                  bus.rdata = '0;
    endcase
  end

  //----------------------------------------
  // datapath
  //----------------------------------------
  assign diff = setpoint - sample_i;  // 15 bit, cannot overflow

  // stage 2 comb: scale, clamp, add level, clamp again
  always_comb
  begin
    shifted = prod_q >>> KP_SHIFT;
    p_sat   = saturate(shifted);
    sum     = p_sat + level;
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      prod_q   <= '0;
      result_o <= '0;
    end
    else
    begin
      prod_q   <= kp * diff;      // stage 1
      result_o <= saturate(sum);  // stage 2
    end
  end

endmodule

/* dac_formatter.sv */
// DAC output register for both channels
// two's complement back to negative slope offset code

module dac_formatter
(
  input  logic                               adc_clk,
  input  logic                               reset_i,
  input  pitaya_pkg::sample_t                result_i [pitaya_pkg::N_CH],
  output logic [pitaya_pkg::SAMPLE_W-1:0]    dac_dat_a_o,  // ch a code
  output logic [pitaya_pkg::SAMPLE_W-1:0]    dac_dat_b_o   // ch b code
);

  //----------------------------------------
  // output register
  //----------------------------------------
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      // code of a zero sample, 0x1fff
      dac_dat_a_o <= pitaya_pkg::neg_slope('0);
      dac_dat_b_o <= pitaya_pkg::neg_slope('0);
    end
    else
    begin
      dac_dat_a_o <= pitaya_pkg::neg_slope(result_i[0]);
      dac_dat_b_o <= pitaya_pkg::neg_slope(result_i[1]);
    end
  end

endmodule

/* pitaya_core.sv */
// top level of the analog core: ADC front end, bus hub,
// generate loop of feedback channels and DAC formatter

module pitaya_core
#(
  parameter int KP_SHIFT = 8  // proportional scaling for every channel
)
(
  input  logic                              adc_clk,
  input  logic                              reset_i,
  // ADC
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]  adc_dat_a_i,
  input  logic [pitaya_pkg::ADC_PIN_W-1:0]  adc_dat_b_i,
  // Wishbone classic slave
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [pitaya_pkg::ADDR_W-1:0]     wb_adr_i,
  input  logic [pitaya_pkg::DATA_W-1:0]     wb_dat_i,
  output logic [pitaya_pkg::DATA_W-1:0]     wb_dat_o,
  output logic                              wb_ack_o,
  // DAC
  output logic [pitaya_pkg::SAMPLE_W-1:0]   dac_dat_a_o,
  output logic [pitaya_pkg::SAMPLE_W-1:0]   dac_dat_b_o,
  // LED
  output logic [7:0]                        led_o
);

  pitaya_pkg::sample_t adc_sample [pitaya_pkg::N_CH];  // 1 cycle after pins
  pitaya_pkg::sample_t ch_result  [pitaya_pkg::N_CH];  // 3 cycles after pins

  // regions 1.. are the channels, region 0 stays inside the hub
  reg_bus_if reg_bus [1:pitaya_pkg::N_REGION-1] ();

  //----------------------------------------
  // ADC in
  //----------------------------------------
  adc_frontend u_adc_frontend
  (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sample_o    (adc_sample)
  );

  //----------------------------------------
  // register bus
  //----------------------------------------
  bus_hub u_bus_hub
  (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .led_o    (led_o),
    .ch_bus   (reg_bus)
  );

  // channel i answers on region i+1
  for (genvar i = 0; i < pitaya_pkg::N_CH; i++)
  begin : g_ch
    feedback_channel #(
      .KP_SHIFT (KP_SHIFT)
    ) u_feedback_channel (
      .adc_clk  (adc_clk),
      .reset_i  (reset_i),
      .bus      (reg_bus[i+1]),
      .sample_i (adc_sample[i]),
      .result_o (ch_result[i])
    );
  end

  //----------------------------------------
  // DAC out
  //----------------------------------------
  dac_formatter u_dac_formatter
  (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .result_i    (ch_result),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* tb_pitaya_core.sv */
// directed testbench for the analog core
// Wishbone bus tasks, channel reference model, one task per test

module tb_pitaya_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int KP_SHIFT    = 8;
  localparam int ACK_TIMEOUT = 16;  // cycles

  logic        adc_clk;
  logic        reset;
  logic [15:0] adc_dat_a;
  logic [15:0] adc_dat_b;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [13:0] dac_a;
  logic [13:0] dac_b;
  logic [7:0]  led;

  int          seed = 92426;
  int          sp [2];           // shadow of the channel registers
  int          kpv [2];
  int          lvl [2];
  logic [13:0] adc_code [2];     // code now on the pins

  pitaya_core #(
    .KP_SHIFT (KP_SHIFT)
  ) u_pitaya_core (
    .adc_clk     (adc_clk),
    .reset_i     (reset),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;  // 8 ns
  end

  //----------------------------------------
  // reporting
  //----------------------------------------
  task automatic stop_failed();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  //----------------------------------------
  // reference model
  //----------------------------------------
  // neg slope code -> signed sample: msb kept, low 13 bits inverted
  function automatic int code_to_sample(input logic [13:0] code);
    logic [13:0] bits;
    bits = {code[13], ~code[12:0]};
    return $signed(bits);
  endfunction

  function automatic int clamp14(input int x);
    if (x > 8191)
      return 8191;
    if (x < -8192)
      return -8192;
    return x;
  endfunction

  function automatic logic [13:0] sample_to_dac(input int r);
    logic [13:0] bits;
    bits = r[13:0];
    return {bits[13], ~bits[12:0]};
  endfunction

  // p term clamped first, then level added and clamped again
  function automatic logic [13:0] model_dac(input int s, input int k, input int l,
                                            input logic [13:0] code);
    int diff;
    int p;
    diff = s - code_to_sample(code);
    p    = clamp14((k * diff) >>> KP_SHIFT);
    return sample_to_dac(clamp14(p + l));
  endfunction

  function automatic int rand_signed(input int bits);
    int v;
    v = $random(seed) & ((1 << bits) - 1);
    if (v >= (1 << (bits - 1)))
      v = v - (1 << bits);  // sign extend
    return v;
  endfunction

  function automatic logic [7:0] reg_addr(input int region, input int offset);
    return {region[3:0], offset[1:0], 2'b00};  // byte address
  endfunction

  //----------------------------------------
  // bus and pin helpers
  //----------------------------------------
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!wb_ack && n < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (!wb_ack)
    begin
      $display("no Wishbone ack within %0d cycles on %s", ACK_TIMEOUT, what);
      stop_failed();
    end
    wb_cyc = 1'b0;  // release after ack
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
    @(negedge adc_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack("write");
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
    @(negedge adc_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack("read");
    data = wb_dat_r;  // registered on the ack edge
  endtask

  task automatic set_channel(input int ch, input int s, input int k, input int l);
    wb_write(reg_addr(ch + 1, pitaya_pkg::REG_SETPOINT), 32'(s));
    wb_write(reg_addr(ch + 1, pitaya_pkg::REG_KP), 32'(k));
    wb_write(reg_addr(ch + 1, pitaya_pkg::REG_LEVEL), 32'(l));
    sp[ch]  = s;
    kpv[ch] = k;
    lvl[ch] = l;
  endtask

  // unused pin bits get noise, they must not matter
  task automatic drive_adc(input logic [13:0] code_a, input logic [13:0] code_b);
    adc_code[0] = code_a;
    adc_code[1] = code_b;
    adc_dat_a   = {code_a, 2'($random(seed))};
    adc_dat_b   = {code_b, 2'($random(seed))};
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  task automatic check_dacs(input string what);
    check_value(dac_a, model_dac(sp[0], kpv[0], lvl[0], adc_code[0]), {what, " dac a"});
    check_value(dac_b, model_dac(sp[1], kpv[1], lvl[1], adc_code[1]), {what, " dac b"});
  endtask

  //----------------------------------------
  // tests
  //----------------------------------------
  task automatic check_reset_state();
    check_value(dac_a, 14'h1FFF, "reset dac a");
    check_value(dac_b, 14'h1FFF, "reset dac b");
    check_value(led, 8'h00, "reset led");
    check_value(wb_ack, 1'b0, "reset ack");
  endtask

  task automatic run_housekeeping();
    logic [31:0] rd;
    wb_read(reg_addr(0, pitaya_pkg::HK_ID), rd);
    check_value(rd, pitaya_pkg::CORE_ID, "core id");
    wb_write(reg_addr(0, pitaya_pkg::HK_LED), 32'hFFFF_FFA5);  // upper bits dropped
    check_value(led, 8'hA5, "led pins");
    wb_read(reg_addr(0, pitaya_pkg::HK_LED), rd);
    check_value(rd, 32'h0000_00A5, "led readback");
    wb_read(reg_addr(5, 0), rd);
    check_value(rd, 32'h0, "unmapped region 5");
  endtask

  task automatic readback_regs();
    logic [31:0] rd;
    set_channel(0, -1234, -300, -5000);
    set_channel(1, -77, -32768, -8192);  // both written before any read
    for (int ch = 0; ch < 2; ch++)
    begin
      wb_read(reg_addr(ch + 1, pitaya_pkg::REG_SETPOINT), rd);
      check_value(rd, 32'(sp[ch]), "setpoint readback");
      wb_read(reg_addr(ch + 1, pitaya_pkg::REG_KP), rd);
      check_value(rd, 32'(kpv[ch]), "kp readback");
      wb_read(reg_addr(ch + 1, pitaya_pkg::REG_LEVEL), rd);
      check_value(rd, 32'(lvl[ch]), "level readback");
      wb_read(reg_addr(ch + 1, 3), rd);
      check_value(rd, 32'h0, "offset 3 readback");
    end
  endtask

  task automatic level_passthrough();
    for (int i = 0; i < 4; i++)
    begin
      set_channel(0, rand_signed(14), 0, rand_signed(14));
      set_channel(1, rand_signed(14), 0, rand_signed(14));
      @(negedge adc_clk);
      drive_adc(14'($random(seed)), 14'($random(seed)));
      wait_cycles(4);
      check_dacs("level passthrough");
    end
  endtask

  task automatic proportional_saturation();
    for (int i = 0; i < 12; i++)
    begin
      // alternate small and full range gains
      set_channel(0, rand_signed(14), rand_signed(i % 2 ? 16 : 10), rand_signed(12));
      set_channel(1, rand_signed(14), rand_signed(i % 2 ? 16 : 10), rand_signed(12));
      @(negedge adc_clk);
      drive_adc(14'($random(seed)), 14'($random(seed)));
      wait_cycles(4);
      check_dacs("proportional");
    end
    // full scale error, max gain: ch a pinned high, ch b pinned low
    set_channel(0, 8191, 32767, 100);
    set_channel(1, -8192, 32767, -100);
    @(negedge adc_clk);
    drive_adc(14'h3FFF, 14'h0000);  // sample -8192 and +8191
    wait_cycles(4);
    check_value(dac_a, 14'h0000, "saturation at +8191");
    check_value(dac_b, 14'h3FFF, "saturation at -8192");
    check_dacs("saturation");
  endtask

  task automatic stream_samples();
    logic [13:0] hist_a [$];
    logic [13:0] hist_b [$];
    set_channel(0, rand_signed(14), rand_signed(12), rand_signed(12));
    set_channel(1, rand_signed(14), rand_signed(12), rand_signed(12));
    for (int k = 0; k < 40; k++)
    begin
      @(negedge adc_clk);
      if (k >= 4)  // pipeline full, output belongs to input k-4
      begin
        check_value(dac_a, model_dac(sp[0], kpv[0], lvl[0], hist_a[k-4]), "stream dac a");
        check_value(dac_b, model_dac(sp[1], kpv[1], lvl[1], hist_b[k-4]), "stream dac b");
      end
      drive_adc(14'($random(seed)), 14'($random(seed)));
      hist_a.push_back(adc_code[0]);
      hist_b.push_back(adc_code[1]);
    end
  endtask

  //----------------------------------------
  // sequence
  //----------------------------------------
  initial
  begin
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    drive_adc(14'h0, 14'h0);
    wait_cycles(3);  // 3 rising edges in reset
    reset = 1'b0;
    check_reset_state();
    run_housekeeping();
    readback_regs();
    level_passthrough();
    proportional_saturation();
    stream_samples();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* project.f */
pitaya_pkg.sv
reg_bus_if.sv
adc_frontend.sv
bus_hub.sv
feedback_channel.sv
dac_formatter.sv
pitaya_core.sv
tb_pitaya_core.sv
